//--- Makefile
# Verilator build and run of the convolution engine testbench

sim:
	verilator --binary --timing --assert -Wno-fatal -f cad.f \
		--top-module cad_tb -Mdir obj_dir -o cad_sim
	./obj_dir/cad_sim

clean:
	rm -rf obj_dir

.PHONY: sim clean

//--- cad.f
+incdir+include
src/cad_data_pkg.sv
src/cad_ctrl_pkg.sv
src/cad_ctrl_fsm.sv
src/cad_window_counter.sv
src/cad_matrix_store.sv
src/cad_mac_pool.sv
src/cad_top.sv
dv/cad_asserts.sv
dv/cad_tb.sv

//--- dv/cad_asserts.sv
/*
 * Concurrent checks on the engine top level:
 * output credits, request handshake and state encoding
 */
`timescale 1ns/1ns
`include "cad_consts.svh"

module cad_asserts
  import cad_ctrl_pkg::*;
(
  input logic       clk,
  input logic       rst_n,
  input cad_state_e state,
  input logic       in_valid2,
  input logic       req_ready,
  input logic       out_valid,
  input logic       credit_return
);

  // Results the consumer can still accept
  logic [3:0] avail;
  int         fail_cnt;

  initial
  begin
    fail_cnt = 0;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      avail <= 4'(`CAD_CREDITS);
    else
      avail <= avail + 4'(credit_return) - 4'(out_valid);
  end

  a_credit: assert property (@(posedge clk) disable iff (!rst_n) out_valid |-> (avail != '0))
  else
  begin
    fail_cnt = fail_cnt + 1;
    $error("out_valid raised with no output credit left");
  end

  // A taken request drops ready on the next cycle
  a_ready: assert property (@(posedge clk) disable iff (!rst_n)
                            (req_ready && in_valid2) |=> !req_ready)
  else
  begin
    fail_cnt = fail_cnt + 1;
    $error("req_ready still high the cycle after a request was taken");
  end

  a_state: assert property (@(posedge clk) disable iff (!rst_n) !$isunknown(state))
  else
  begin
    fail_cnt = fail_cnt + 1;
    $error("state holds an unknown value");
  end

endmodule

//--- dv/cad_tb.sv
/*
 * Directed tests for the convolution engine: load, requests,
 * credit stall and stray requests, with a conv and max-pool model
 */
`timescale 1ns/1ns
`include "cad_consts.svh"

module cad_tb
  import cad_data_pkg::*;
  import cad_ctrl_pkg::*;
();

  localparam int IMG_SZ    = `CAD_IMG_DIM * `CAD_IMG_DIM;
  localparam int KER_SZ    = `CAD_KER_DIM * `CAD_KER_DIM;
  localparam int IMG_BYTES = `CAD_NUM_MATS * IMG_SZ;
  localparam int KER_BYTES = `CAD_NUM_MATS * KER_SZ;
  localparam int WSIDE     = `CAD_CONV_DIM / `CAD_POOL_DIM;
  // Tests take about 8000 cycles at most
  localparam int TIMEOUT_CYCLES = 20000;

  logic        clk;
  logic        rst_n;
  logic        in_valid;
  pixel_t      matrix;
  logic        in_valid2;
  cad_req_t    req;
  logic        req_ready;
  logic        out_valid;
  cad_result_t out_result;
  logic        credit_return;

  pixel_t      img_data [IMG_BYTES];
  pixel_t      ker_data [KER_BYTES];
  logic [31:0] rng_state;
  int          cycle_cnt;

  cad_top u_cad_top (
    .clk           (clk),
    .rst_n         (rst_n),
    .in_valid      (in_valid),
    .matrix        (matrix),
    .in_valid2     (in_valid2),
    .req           (req),
    .req_ready     (req_ready),
    .out_valid     (out_valid),
    .out_result    (out_result),
    .credit_return (credit_return)
  );

  bind cad_top cad_asserts u_cad_asserts (
    .clk           (clk),
    .rst_n         (rst_n),
    .state         (state),
    .in_valid2     (in_valid2),
    .req_ready     (req_ready),
    .out_valid     (out_valid),
    .credit_return (credit_return)
  );

  always #2 clk = ~clk;

  always @(posedge clk)
  begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES)
    begin
      $display("Run did not finish within %0d cycles", TIMEOUT_CYCLES);
      abort_run();
    end
  end

  //--------------------------------------------------------------------------
  // Helpers and checks
  //--------------------------------------------------------------------------
  task automatic abort_run();
    $display("TESTBENCH FAILED");
    $fatal(1, "stopping at first error");
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic refill_data();
    for (int i = 0; i < IMG_BYTES + KER_BYTES; i++)
    begin
      rng_state = xorshift32(rng_state);
      if (i < IMG_BYTES)
        img_data[i] = pixel_t'(rng_state[7:0]);
      else
        ker_data[i - IMG_BYTES] = pixel_t'(rng_state[7:0]);
    end
  endtask

  // Max of the four conv points in pool window win, raster order
  function automatic cad_result_t pool_model(input int img, input int ker, input int win);
    cad_result_t res;
    int best;
    int sum;
    int r0;
    int c0;
    best = 0;
    for (int p = 0; p < `CAD_POOL_DIM * `CAD_POOL_DIM; p++)
    begin
      r0  = (win / WSIDE) * `CAD_POOL_DIM + p / `CAD_POOL_DIM;
      c0  = (win % WSIDE) * `CAD_POOL_DIM + p % `CAD_POOL_DIM;
      sum = 0;
      for (int kr = 0; kr < `CAD_KER_DIM; kr++)
        for (int kc = 0; kc < `CAD_KER_DIM; kc++)
          sum += int'(img_data[img * IMG_SZ + (r0 + kr) * `CAD_IMG_DIM + c0 + kc]) *
                 int'(ker_data[ker * KER_SZ + kr * `CAD_KER_DIM + kc]);
      if (p == 0 || sum > best)
        best = sum;
    end
    res.value = acc_t'(best);
    return res;
  endfunction

  task automatic check_result(input string test, input cad_result_t exp, input cad_result_t act);
    if (exp !== act)
    begin
      $display("FAIL %s: result expected %0d, got %0d", test, exp.value, act.value);
      abort_run();
    end
  endtask

  task automatic check_state(input string test, input cad_state_e exp, input cad_state_e act);
    if (exp !== act)
    begin
      $display("FAIL %s: state expected %s, got %s", test, exp.name(), act.name());
      abort_run();
    end
  endtask

  task automatic check_bit(input string test, input string what, input logic exp,
                           input logic act);
    if (exp !== act)
    begin
      $display("FAIL %s: %s expected %b, got %b", test, what, exp, act);
      abort_run();
    end
  endtask

  //--------------------------------------------------------------------------
  // Stimulus
  //--------------------------------------------------------------------------
  task automatic load_matrices();
    for (int i = 0; i < IMG_BYTES + KER_BYTES; i++)
    begin
      in_valid = 1'b1;
      matrix   = (i < IMG_BYTES) ? img_data[i] : ker_data[i - IMG_BYTES];
      next_cycle();
    end
    in_valid = 1'b0;
    matrix   = '0;
  endtask

  task automatic send_request(input int img, input int ker);
    while (!req_ready)
      next_cycle();
    in_valid2   = 1'b1;
    req.img_idx = mat_idx_t'(img);
    req.ker_idx = mat_idx_t'(ker);
    next_cycle();
    in_valid2 = 1'b0;
  endtask

  // Waits for count results from window first_w on, optionally returning credits
  task automatic collect_results(input string test, input int img, input int ker,
                                 input int first_w, input int count, input logic give_back);
    int got;
    got = 0;
    while (got < count)
    begin
      next_cycle();
      credit_return = 1'b0;
      if (out_valid)
      begin
        check_result(test, pool_model(img, ker, first_w + got), out_result);
        credit_return = give_back;
        got++;
      end
    end
    next_cycle();
    credit_return = 1'b0;
  endtask

  task automatic expect_quiet(input string test, input int cycles, input logic ready_exp);
    for (int i = 0; i < cycles; i++)
    begin
      check_bit(test, "out_valid", 1'b0, out_valid);
      check_bit(test, "req_ready", ready_exp, req_ready);
      next_cycle();
    end
  endtask

  //--------------------------------------------------------------------------
  // Tests
  //--------------------------------------------------------------------------
  task automatic test_reset_quiet();
    expect_quiet("reset_quiet", 20, 1'b0);
  endtask

  task automatic test_first_request();
    refill_data();
    load_matrices();
    send_request(0, 0);
    collect_results("first_request", 0, 0, 0, 4, 1'b1);
    check_bit("first_request", "req_ready", 1'b1, req_ready);
  endtask

  task automatic test_remaining_requests();
    send_request(1, 2);
    collect_results("remaining_requests", 1, 2, 0, 4, 1'b1);
    send_request(2, 3);
    collect_results("remaining_requests", 2, 3, 0, 4, 1'b1);
    send_request(3, 1);
    collect_results("remaining_requests", 3, 1, 0, 4, 1'b1);
    next_cycle();
    check_state("remaining_requests", ST_IDLE, u_cad_top.state);
    expect_quiet("remaining_requests", 20, 1'b0);
  endtask

  task automatic test_credit_stall();
    refill_data();
    load_matrices();
    send_request(2, 0);
    collect_results("credit_stall", 2, 0, 0, 2, 1'b0);
    expect_quiet("credit_stall", 300, 1'b0);
    // Two separate one-cycle returns
    credit_return = 1'b1;
    next_cycle();
    credit_return = 1'b0;
    next_cycle();
    credit_return = 1'b1;
    next_cycle();
    credit_return = 1'b0;
    collect_results("credit_stall", 2, 0, 2, 2, 1'b1);
  endtask

  task automatic test_stray_request();
    send_request(3, 2);
    // Stray request while computing must be ignored
    in_valid2   = 1'b1;
    req.img_idx = mat_idx_t'(0);
    req.ker_idx = mat_idx_t'(0);
    next_cycle();
    in_valid2 = 1'b0;
    collect_results("stray_request", 3, 2, 0, 4, 1'b1);
    expect_quiet("stray_request", 50, 1'b1);
    send_request(1, 0);
    collect_results("stray_request", 1, 0, 0, 4, 1'b1);
  endtask

  initial
  begin
    clk           = 1'b0;
    rst_n         = 1'b0;
    in_valid      = 1'b0;
    matrix        = '0;
    in_valid2     = 1'b0;
    req           = '0;
    credit_return = 1'b0;
    cycle_cnt     = 0;
    rng_state     = 32'h2865b9d7;
    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;
    test_reset_quiet();
    test_first_request();
    test_remaining_requests();
    test_credit_stall();
    test_stray_request();
    if (u_cad_top.u_cad_asserts.fail_cnt != 0)
    begin
      $display("Bound assertions failed %0d times", u_cad_top.u_cad_asserts.fail_cnt);
      abort_run();
    end
    else
    begin
      $display("TESTBENCH PASSED");
      $finish;
    end
  end

endmodule

//--- include/cad_consts.svh
/*
 * Engine sizes, accumulator width, output credits and requests per load
 */
`ifndef CAD_CONSTS_SVH
`define CAD_CONSTS_SVH

//--------------------------------------------------------------------------
// Matrix geometry
//--------------------------------------------------------------------------
`define CAD_IMG_DIM 8
`define CAD_KER_DIM 5
`define CAD_NUM_MATS 4

// Valid conv output side and pool window side
`define CAD_CONV_DIM 4
`define CAD_POOL_DIM 2

//--------------------------------------------------------------------------
// Datapath and flow control
//--------------------------------------------------------------------------
`define CAD_ACC_W 20

// Output credits granted after reset
`define CAD_CREDITS 2
`define CAD_REQS_PER_LOAD 4

`endif

//--- src/cad_ctrl_fsm.sv
/*
 * Phase FSM with request, pool window and output credit counters
 */
`timescale 1ns/1ns
`include "cad_consts.svh"

module cad_ctrl_fsm
  import cad_ctrl_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       in_valid,
  input  logic       in_valid2,
  input  cad_req_t   req,
  input  logic       load_done,
  input  logic       win_done,
  input  logic       credit_return,
  output cad_state_e state,
  output logic       req_ready,
  output cad_req_t   cur_req,
  output logic       win_go
);

  localparam int WINS_SIDE = `CAD_CONV_DIM / `CAD_POOL_DIM;
  localparam int WINS      = WINS_SIDE * WINS_SIDE;
  // Read, accumulate and pool register stages
  localparam int PIPE_LAT  = 3;
  localparam int CRED_W    = $clog2(`CAD_CREDITS + 1);
  localparam int REQ_W     = $clog2(`CAD_REQS_PER_LOAD + 1);
  localparam int WIN_W     = $clog2(WINS + 1);
  localparam int DRAIN_W   = $clog2(PIPE_LAT + 1);

  cad_state_e         state_nxt;
  logic               req_take;
  logic               last_done;
  logic               req_fin;
  logic [REQ_W-1:0]   req_cnt;
  logic [WIN_W-1:0]   win_cnt;
  logic               win_active;
  logic [CRED_W-1:0]  credits;
  logic [DRAIN_W-1:0] drain;

  assign req_ready = (state == ST_WAIT_REQ);
  assign req_take  = req_ready && in_valid2;

  // Next window may follow the previous one back to back
  assign win_go = (state == ST_COMPUTE) && (win_cnt != WIN_W'(WINS)) &&
                  (!win_active || win_done) && (credits != '0);

  assign last_done = win_done && (win_cnt == WIN_W'(WINS));
  // Last result leaves the pool register this cycle
  assign req_fin   = (drain == DRAIN_W'(1));

  always_comb
  begin
    state_nxt = state;
    case (state)
      ST_IDLE:     if (in_valid) state_nxt = ST_LOAD;
      ST_LOAD:     if (load_done) state_nxt = ST_WAIT_REQ;
      ST_WAIT_REQ: if (req_take) state_nxt = ST_COMPUTE;
      ST_COMPUTE:
      begin
        if (req_fin)
          state_nxt = (req_cnt == REQ_W'(`CAD_REQS_PER_LOAD)) ? ST_IDLE : ST_WAIT_REQ;
      end
      default:     state_nxt = ST_IDLE;
    endcase
  end

  //--------------------------------------------------------------------------
  // State and counters
  //--------------------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state      <= ST_IDLE;
      req_cnt    <= '0;
      win_cnt    <= '0;
      win_active <= 1'b0;
      credits    <= CRED_W'(`CAD_CREDITS);
      drain      <= '0;
    end
    else
    begin
      state <= state_nxt;

      if (state == ST_IDLE)
        req_cnt <= '0;
      else if (req_take)
        req_cnt <= req_cnt + 1'b1;

      if (req_take)
        win_cnt <= '0;
      else if (win_go)
        win_cnt <= win_cnt + 1'b1;

      if (win_go)
        win_active <= 1'b1;
      else if (win_done)
        win_active <= 1'b0;

      credits <= credits + CRED_W'(credit_return) - CRED_W'(win_go);

      if (last_done)
        drain <= DRAIN_W'(PIPE_LAT);
      else if (drain != '0)
        drain <= drain - 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (req_take)
      cur_req <= req;
  end

endmodule

//--- src/cad_ctrl_pkg.sv
/*
 * Control types: engine state, request,
 * MAC tags and result word
 */
package cad_ctrl_pkg;

  import cad_data_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_LOAD,
    ST_WAIT_REQ,
    ST_COMPUTE
  } cad_state_e;

  // One request, image and kernel taken in the same cycle
  typedef struct packed {
    mat_idx_t img_idx;
    mat_idx_t ker_idx;
  } cad_req_t;

  // Tags travelling with each memory read
  typedef struct packed {
    logic first;
    logic last_tap;
    logic last_in_window;
  } mac_ctrl_t;

  typedef struct packed {
    acc_t value;
  } cad_result_t;

endpackage

//--- src/cad_data_pkg.sv
/*
 * Data types: pixel, accumulator, matrix index,
 * image and kernel memory addresses, matrix coordinate
 */
`include "cad_consts.svh"

package cad_data_pkg;

  // One input byte of an image or a kernel
  typedef logic signed [7:0] pixel_t;

  // Sum of 25 products, also the pooled result
  typedef logic signed [`CAD_ACC_W-1:0] acc_t;

  // Selects one of the stored images or kernels
  typedef logic [$clog2(`CAD_NUM_MATS)-1:0] mat_idx_t;

  // Byte address over all images
  typedef logic [$clog2(`CAD_NUM_MATS * `CAD_IMG_DIM * `CAD_IMG_DIM)-1:0] img_addr_t;

  // Byte address over all kernels
  typedef logic [$clog2(`CAD_NUM_MATS * `CAD_KER_DIM * `CAD_KER_DIM)-1:0] ker_addr_t;

  // Row or column inside a matrix
  typedef logic [$clog2(`CAD_IMG_DIM)-1:0] coord_t;

endpackage

//--- src/cad_mac_pool.sv
/*
 * Sequential multiply-accumulate, 2x2 max-pool fold and result register
 */
`timescale 1ns/1ns

module cad_mac_pool
  import cad_data_pkg::*;
  import cad_ctrl_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  pixel_t      img_pix,
  input  pixel_t      ker_pix,
  input  mac_ctrl_t   mac_ctrl,
  output logic        out_valid,
  output cad_result_t out_result
);

  mac_ctrl_t ctrl_d1;
  acc_t      prod;
  acc_t      acc;
  acc_t      max_val;
  acc_t      max_nxt;
  // Accumulator holds a finished conv point
  logic      sum_done;
  logic      sum_last;
  logic      max_empty;

  // Sign extended to the accumulator width before the multiply
  assign prod = img_pix * ker_pix;

  assign max_nxt = (max_empty || (acc > max_val)) ? acc : max_val;

  //--------------------------------------------------------------------------
  // Control pipe
  //--------------------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      ctrl_d1   <= '0;
      sum_done  <= 1'b0;
      sum_last  <= 1'b0;
      max_empty <= 1'b1;
      out_valid <= 1'b0;
    end
    else
    begin
      ctrl_d1   <= mac_ctrl;
      sum_done  <= ctrl_d1.last_tap;
      sum_last  <= ctrl_d1.last_in_window;
      out_valid <= sum_done && sum_last;
      // Window ends empty, inner points keep the max live
      if (sum_done)
        max_empty <= sum_last;
    end
  end

  //--------------------------------------------------------------------------
  // Datapath
  //--------------------------------------------------------------------------
  always_ff @(posedge clk)
  begin
    acc <= (ctrl_d1.first ? acc_t'(0) : acc) + prod;

    if (sum_done && !sum_last)
      max_val <= max_nxt;

    if (sum_done && sum_last)
      out_result.value <= max_nxt;
  end

endmodule

//--- src/cad_matrix_store.sv
/*
 * Image and kernel register memories,
 * load writes and registered compute reads
 */
`timescale 1ns/1ns
`include "cad_consts.svh"

module cad_matrix_store
  import cad_data_pkg::*;
  import cad_ctrl_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  cad_state_e state,
  input  pixel_t     matrix,
  input  logic       in_valid,
  input  img_addr_t  img_addr,
  input  ker_addr_t  ker_addr,
  output pixel_t     img_pix,
  output pixel_t     ker_pix
);

  localparam int IMG_AREA = `CAD_NUM_MATS * `CAD_IMG_DIM * `CAD_IMG_DIM;
  localparam int KER_AREA = `CAD_NUM_MATS * `CAD_KER_DIM * `CAD_KER_DIM;

  pixel_t img_mem [IMG_AREA];
  pixel_t ker_mem [KER_AREA];

  logic wr_en;
  logic img_last;
  logic ker_phase;

  //--------------------------------------------------------------------------
  // Load side
  //--------------------------------------------------------------------------
  assign wr_en    = in_valid && ((state == ST_IDLE) || (state == ST_LOAD));
  assign img_last = (img_addr == img_addr_t'(IMG_AREA - 1));

  // Set once the last image byte has been written
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      ker_phase <= 1'b0;
    else if (state != ST_LOAD)
      ker_phase <= 1'b0;
    else if (wr_en && img_last)
      ker_phase <= 1'b1;
  end

  always_ff @(posedge clk)
  begin
    if (wr_en && !ker_phase)
      img_mem[img_addr] <= matrix;
  end

  always_ff @(posedge clk)
  begin
    if (wr_en && ker_phase)
      ker_mem[ker_addr] <= matrix;
  end

  //--------------------------------------------------------------------------
  // Compute side
  //--------------------------------------------------------------------------
  // Data lines up with the delayed MAC tags
  always_ff @(posedge clk)
  begin
    if (state == ST_COMPUTE)
    begin
      img_pix <= img_mem[img_addr];
      ker_pix <= ker_mem[ker_addr];
    end
  end

endmodule

//--- src/cad_top.sv
/*
 * Engine top level: FSM, window counter, matrix store, MAC and pool
 */
`timescale 1ns/1ns

module cad_top
  import cad_data_pkg::*;
  import cad_ctrl_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        in_valid,
  input  pixel_t      matrix,
  input  logic        in_valid2,
  input  cad_req_t    req,
  output logic        req_ready,
  output logic        out_valid,
  output cad_result_t out_result,
  input  logic        credit_return
);

  cad_state_e state;
  cad_req_t   cur_req;
  logic       win_go;
  logic       load_done;
  logic       win_done;
  img_addr_t  img_addr;
  ker_addr_t  ker_addr;
  mac_ctrl_t  mac_ctrl;
  pixel_t     img_pix;
  pixel_t     ker_pix;

  cad_ctrl_fsm u_ctrl_fsm (
    .clk           (clk),
    .rst_n         (rst_n),
    .in_valid      (in_valid),
    .in_valid2     (in_valid2),
    .req           (req),
    .load_done     (load_done),
    .win_done      (win_done),
    .credit_return (credit_return),
    .state         (state),
    .req_ready     (req_ready),
    .cur_req       (cur_req),
    .win_go        (win_go)
  );

  cad_window_counter u_window_counter (
    .clk       (clk),
    .rst_n     (rst_n),
    .state     (state),
    .win_go    (win_go),
    .cur_req   (cur_req),
    .load_done (load_done),
    .win_done  (win_done),
    .img_addr  (img_addr),
    .ker_addr  (ker_addr),
    .mac_ctrl  (mac_ctrl)
  );

  cad_matrix_store u_matrix_store (
    .clk      (clk),
    .rst_n    (rst_n),
    .state    (state),
    .matrix   (matrix),
    .in_valid (in_valid),
    .img_addr (img_addr),
    .ker_addr (ker_addr),
    .img_pix  (img_pix),
    .ker_pix  (ker_pix)
  );

  cad_mac_pool u_mac_pool (
    .clk        (clk),
    .rst_n      (rst_n),
    .img_pix    (img_pix),
    .ker_pix    (ker_pix),
    .mac_ctrl   (mac_ctrl),
    .out_valid  (out_valid),
    .out_result (out_result)
  );

endmodule

//--- src/cad_window_counter.sv
/*
 * Load write address counter, conv and pool position counters,
 * read address generation and MAC tags
 */
`timescale 1ns/1ns
`include "cad_consts.svh"

module cad_window_counter
  import cad_data_pkg::*;
  import cad_ctrl_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  cad_state_e state,
  input  logic       win_go,
  input  cad_req_t   cur_req,
  output logic       load_done,
  output logic       win_done,
  output img_addr_t  img_addr,
  output ker_addr_t  ker_addr,
  output mac_ctrl_t  mac_ctrl
);

  localparam int IMG_SZ     = `CAD_IMG_DIM * `CAD_IMG_DIM;
  localparam int KER_SZ     = `CAD_KER_DIM * `CAD_KER_DIM;
  localparam int IMG_AREA   = `CAD_NUM_MATS * IMG_SZ;
  localparam int LOAD_BYTES = IMG_AREA + `CAD_NUM_MATS * KER_SZ;
  localparam int LD_W       = $clog2(LOAD_BYTES);
  localparam int KLAST      = `CAD_KER_DIM - 1;
  localparam int PLAST      = `CAD_POOL_DIM - 1;
  localparam int WLAST      = `CAD_CONV_DIM / `CAD_POOL_DIM - 1;

  logic [LD_W-1:0] load_cnt;
  logic [LD_W-1:0] load_addr;
  logic            busy;
  logic            tap_last;
  logic            point_last;
  coord_t          kc;
  coord_t          kr;
  coord_t          sub_x;
  coord_t          sub_y;
  coord_t          win_x;
  coord_t          win_y;
  coord_t          row;
  coord_t          col;

  //--------------------------------------------------------------------------
  // Load addressing
  //--------------------------------------------------------------------------
  // Byte 0 arrives while still idle
  assign load_addr = (state == ST_LOAD) ? load_cnt : '0;
  assign load_done = (state == ST_LOAD) && (load_cnt == LD_W'(LOAD_BYTES - 1));

  //--------------------------------------------------------------------------
  // Read addressing
  //--------------------------------------------------------------------------
  assign row = coord_t'(win_y * `CAD_POOL_DIM + sub_y + kr);
  assign col = coord_t'(win_x * `CAD_POOL_DIM + sub_x + kc);

  assign tap_last   = (kc == coord_t'(KLAST)) && (kr == coord_t'(KLAST));
  assign point_last = (sub_x == coord_t'(PLAST)) && (sub_y == coord_t'(PLAST));
  assign win_done   = busy && tap_last && point_last;

  assign mac_ctrl.first          = busy && (kc == '0) && (kr == '0);
  assign mac_ctrl.last_tap       = busy && tap_last;
  assign mac_ctrl.last_in_window = busy && point_last;

  always_comb
  begin
    if (state == ST_COMPUTE)
    begin
      img_addr = img_addr_t'(cur_req.img_idx * IMG_SZ + row * `CAD_IMG_DIM + col);
      ker_addr = ker_addr_t'(cur_req.ker_idx * KER_SZ + kr * `CAD_KER_DIM + kc);
    end
    else
    begin
      img_addr = img_addr_t'(load_addr);
      // Kernel area follows the images
      ker_addr = ker_addr_t'(load_addr - LD_W'(IMG_AREA));
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      load_cnt <= LD_W'(1);
    else
      load_cnt <= (state == ST_LOAD) ? load_cnt + 1'b1 : LD_W'(1);
  end

  // Kernel column fastest, then row, pool sub-position, pool window
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      busy  <= 1'b0;
      kc    <= '0;
      kr    <= '0;
      sub_x <= '0;
      sub_y <= '0;
      win_x <= '0;
      win_y <= '0;
    end
    else if (state != ST_COMPUTE)
    begin
      busy  <= 1'b0;
      kc    <= '0;
      kr    <= '0;
      sub_x <= '0;
      sub_y <= '0;
      win_x <= '0;
      win_y <= '0;
    end
    else
    begin
      if (win_go)
        busy <= 1'b1;
      else if (win_done)
        busy <= 1'b0;

      if (busy)
      begin
        kc <= (kc == coord_t'(KLAST)) ? '0 : kc + 1'b1;
        if (kc == coord_t'(KLAST))
          kr <= (kr == coord_t'(KLAST)) ? '0 : kr + 1'b1;
        if (tap_last)
        begin
          sub_x <= (sub_x == coord_t'(PLAST)) ? '0 : sub_x + 1'b1;
          if (sub_x == coord_t'(PLAST))
            sub_y <= (sub_y == coord_t'(PLAST)) ? '0 : sub_y + 1'b1;
        end
        if (win_done)
        begin
          win_x <= (win_x == coord_t'(WLAST)) ? '0 : win_x + 1'b1;
          if (win_x == coord_t'(WLAST))
            win_y <= (win_y == coord_t'(WLAST)) ? '0 : win_y + 1'b1;
        end
      end
    end
  end

endmodule
